// ==== build.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/regfile_if.sv
source/stage_latch.sv
source/fetch.sv
source/hazard_unit.sv
source/decode.sv
source/execute.sv
source/data_memory.sv
source/proc_top.sv
tests/proc_properties.sv
tests/proc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and decide on the log contents
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module proc_tb \
   -f build.f -Mdir obj_dir -o proc_tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/proc_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Everything OK$" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== source/data_memory.sv ====
`timescale 1ns/1ps

module data_memory (
   input  logic          clk,
   input  logic          reset,
   input  pipe_pkg::em_t em,
   output pipe_pkg::mw_t mw
);

   isa_pkg::word_t    dmem [isa_pkg::dmem_depth];
   isa_pkg::mem_addr_t addr;
   isa_pkg::word_t    read_data;

   assign addr = em.alu_result[isa_pkg::mem_addr_width-1:0]; // Word addressed

   always_ff @(posedge clk) begin
      if (em.ctrl.mem_write && !reset) begin
         dmem[addr] <= em.store_data;
      end
   end

   assign read_data = em.ctrl.mem_read ? dmem[addr] : '0; // Asynchronous read

   always_comb begin
      mw.reg_write = em.ctrl.reg_write;
      mw.dest      = em.ctrl.dest;
      mw.halt      = em.ctrl.halt;
      if (em.ctrl.link) begin
         mw.wb_value = em.pc_plus2;   // JAL return address
      end else if (em.ctrl.mem_to_reg) begin
         mw.wb_value = read_data;
      end else begin
         mw.wb_value = em.alu_result;
      end
   end

endmodule

// ==== source/decode.sv ====
`timescale 1ns/1ps

module decode (
   input  logic            clk,
   input  logic            reset,
   input  pipe_pkg::fd_t   fd,
   regfile_if.regfile      rf,
   output pipe_pkg::de_t   de,
   output logic            uses_rt,
   output logic            err
);

   typedef enum logic [1:0] {imm_short, imm_branch, imm_jump} imm_sel_t;

   isa_pkg::word_t   regs [isa_pkg::reg_count];
   isa_pkg::opcode_t opcode;
   isa_pkg::reg_sel_t rt_field;
   isa_pkg::reg_sel_t rd_field;
   pipe_pkg::ctrl_t  ctrl;
   imm_sel_t         imm_sel;
   logic             illegal;

   assign opcode   = isa_pkg::opcode_t'(fd.instr[isa_pkg::opcode_lsb +: isa_pkg::opcode_width]);
   assign rt_field = fd.instr[isa_pkg::rt_lsb +: isa_pkg::reg_sel_width];
   assign rd_field = fd.instr[isa_pkg::rd_lsb +: isa_pkg::reg_sel_width];

   assign rf.read1_sel = fd.instr[isa_pkg::rs_lsb +: isa_pkg::reg_sel_width];
   assign rf.read2_sel = rt_field;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < isa_pkg::reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (rf.write) begin
         regs[rf.write_sel] <= rf.write_data;
      end
   end

   // Write-before-read within the same cycle
   assign rf.read1_data = (rf.write && rf.write_sel == rf.read1_sel) ? rf.write_data
                                                                     : regs[rf.read1_sel];
   assign rf.read2_data = (rf.write && rf.write_sel == rf.read2_sel) ? rf.write_data
                                                                     : regs[rf.read2_sel];

   always_comb begin
      ctrl        = '0;
      ctrl.alu_op = isa_pkg::alu_pass_b;
      imm_sel     = imm_short;
      uses_rt     = 1'b0;
      illegal     = 1'b0;
      case (opcode)
         isa_pkg::op_nop: ;
         isa_pkg::op_halt: ctrl.halt = 1'b1;
         isa_pkg::op_addi: begin
            ctrl.reg_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.alu_op      = isa_pkg::alu_add;
            ctrl.dest        = rt_field;
         end
         isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and, isa_pkg::op_xor: begin
            ctrl.reg_write = 1'b1;
            ctrl.dest      = rd_field;
            uses_rt        = 1'b1;
            case (opcode)
               isa_pkg::op_add: ctrl.alu_op = isa_pkg::alu_add;
               isa_pkg::op_sub: ctrl.alu_op = isa_pkg::alu_sub;
               isa_pkg::op_and: ctrl.alu_op = isa_pkg::alu_and;
               default:         ctrl.alu_op = isa_pkg::alu_xor;
            endcase
         end
         isa_pkg::op_ld: begin
            ctrl.reg_write   = 1'b1;
            ctrl.mem_read    = 1'b1;
            ctrl.mem_to_reg  = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.alu_op      = isa_pkg::alu_add; // Address is rs + imm5
            ctrl.dest        = rt_field;
         end
         isa_pkg::op_st: begin
            ctrl.mem_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.alu_op      = isa_pkg::alu_add;
            uses_rt          = 1'b1;             // Store data
         end
         isa_pkg::op_beqz: begin
            ctrl.branch_zero = 1'b1;
            imm_sel          = imm_branch;
         end
         isa_pkg::op_bnez: begin
            ctrl.branch_nonzero = 1'b1;
            imm_sel             = imm_branch;
         end
         isa_pkg::op_j: begin
            ctrl.jump = 1'b1;
            imm_sel   = imm_jump;
         end
         isa_pkg::op_jal: begin
            ctrl.jump      = 1'b1;
            ctrl.link      = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.dest      = isa_pkg::reg_link;
            imm_sel        = imm_jump;
         end
         isa_pkg::op_jr: begin
            ctrl.jump     = 1'b1;
            ctrl.jump_reg = 1'b1;
            imm_sel       = imm_branch;
         end
         default: illegal = 1'b1; // Controls stay cleared, acts as a NOP
      endcase
   end

   always_comb begin
      de.ctrl     = ctrl;
      de.rs_val   = rf.read1_data;
      de.rt_val   = rf.read2_data;
      de.pc_plus2 = fd.pc_plus2;
      case (imm_sel)
         imm_branch: de.imm = isa_pkg::word_t'(signed'(fd.instr[isa_pkg::imm_branch_width-1:0]));
         imm_jump:   de.imm = isa_pkg::word_t'(signed'(fd.instr[isa_pkg::imm_jump_width-1:0]));
         default:    de.imm = isa_pkg::word_t'(signed'(fd.instr[isa_pkg::imm_short_width-1:0]));
      endcase
   end

   // Bubbles decode as NOP, never illegal
   assign err = illegal;

endmodule

// ==== source/execute.sv ====
`timescale 1ns/1ps

module execute (
   input  pipe_pkg::de_t  de,
   output pipe_pkg::em_t  em,
   output logic           taken,
   output isa_pkg::word_t target
);

   isa_pkg::word_t operand_b;
   isa_pkg::word_t alu_result;
   logic           rs_zero;

   assign operand_b = de.ctrl.alu_src_imm ? de.imm : de.rt_val;

   always_comb begin
      case (de.ctrl.alu_op)
         isa_pkg::alu_add: alu_result = de.rs_val + operand_b;
         isa_pkg::alu_sub: alu_result = de.rs_val - operand_b; // rs - rt
         isa_pkg::alu_and: alu_result = de.rs_val & operand_b;
         isa_pkg::alu_xor: alu_result = de.rs_val ^ operand_b;
         default:          alu_result = operand_b;
      endcase
   end

   // Branch test on rs
   assign rs_zero = (de.rs_val == '0);

   assign taken = de.ctrl.jump ||
                  (de.ctrl.branch_zero && rs_zero) ||
                  (de.ctrl.branch_nonzero && !rs_zero);

   // JR is register relative, everything else PC relative
   assign target = de.ctrl.jump_reg ? de.rs_val + de.imm
                                    : de.pc_plus2 + de.imm;

   always_comb begin
      em.ctrl       = de.ctrl;
      em.alu_result = alu_result;
      em.store_data = de.rt_val;
      em.pc_plus2   = de.pc_plus2;
   end

endmodule

// ==== source/fetch.sv ====
`timescale 1ns/1ps

module fetch (
   input  logic               clk,
   input  logic               reset,
   input  logic               load_en,
   input  isa_pkg::mem_addr_t load_addr,
   input  isa_pkg::word_t     load_data,
   input  logic               stall,
   input  logic               redirect,
   input  isa_pkg::word_t     redirect_target,
   input  logic               halt_wb,
   output pipe_pkg::fd_t      fetched,
   output isa_pkg::word_t     pc
);

   isa_pkg::word_t imem [isa_pkg::imem_depth];
   logic halt_fetched;

   // Program load, only while reset is held
   always_ff @(posedge clk) begin
      if (reset && load_en) begin
         imem[load_addr] <= load_data;
      end
   end

   assign fetched.instr    = imem[pc[isa_pkg::mem_addr_width:1]]; // Byte PC, word array
   assign fetched.pc_plus2 = pc + isa_pkg::word_t'(2);

   // Park on a HALT so nothing past it gets fetched
   assign halt_fetched = isa_pkg::opcode_t'(fetched.instr[isa_pkg::opcode_lsb +:
                                            isa_pkg::opcode_width]) == isa_pkg::op_halt;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (halt_wb) begin
         pc <= pc;                      // Frozen for good once HALT retires
      end else if (redirect) begin
         pc <= redirect_target;         // Taken branch or jump from execute
      end else if (!stall && !halt_fetched) begin
         pc <= fetched.pc_plus2;
      end
   end

endmodule

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
   regfile_if.source         src,
   input  logic              uses_rt,
   input  pipe_pkg::ctrl_t   de_ctrl,
   input  pipe_pkg::ctrl_t   em_ctrl,
   input  isa_pkg::reg_sel_t mw_dest,
   input  logic              mw_write,
   input  logic              taken,
   output logic              stall_front,
   output logic              flush_fd,
   output logic              flush_de
);

   logic rs_hit;
   logic rt_hit;
   logic raw;

   // Pending writes in execute, memory and write-back
   assign rs_hit = (de_ctrl.reg_write && de_ctrl.dest == src.read1_sel) ||
                   (em_ctrl.reg_write && em_ctrl.dest == src.read1_sel) ||
                   (mw_write && mw_dest == src.read1_sel);

   assign rt_hit = (de_ctrl.reg_write && de_ctrl.dest == src.read2_sel) ||
                   (em_ctrl.reg_write && em_ctrl.dest == src.read2_sel) ||
                   (mw_write && mw_dest == src.read2_sel);

   // rt only counts for R-type and ST
   assign raw = rs_hit || (uses_rt && rt_hit);

   assign stall_front = raw;          // Hold fetch and the fd latch
   assign flush_fd    = taken;        // Kill the wrong-path fetch
   assign flush_de    = raw || taken; // Bubble into execute

endmodule

// ==== source/isa_pkg.sv ====
package isa_pkg;

   // Architectural sizes
   localparam int word_width     = 16;
   localparam int reg_count      = 8;
   localparam int reg_sel_width  = $clog2(reg_count);
   localparam int imem_depth     = 64;
   localparam int dmem_depth     = 64;
   localparam int mem_addr_width = $clog2(imem_depth);

   typedef logic [word_width-1:0]     word_t;
   typedef logic [reg_sel_width-1:0]  reg_sel_t;
   typedef logic [mem_addr_width-1:0] mem_addr_t;

   // Instruction fields
   localparam int opcode_lsb       = 11;
   localparam int opcode_width     = 5;
   localparam int rs_lsb           = 8;
   localparam int rt_lsb           = 5;
   localparam int rd_lsb           = 2;
   localparam int imm_short_width  = 5;  // ADDI, LD, ST
   localparam int imm_branch_width = 8;  // BEQZ, BNEZ, JR
   localparam int imm_jump_width   = 11; // J, JAL

   localparam reg_sel_t reg_link = 3'd7; // JAL return address

   // All-zero word is a NOP, so a cleared latch decodes as a bubble
   typedef enum logic [opcode_width-1:0] {
      op_nop  = 5'b00000,
      op_halt = 5'b00001,
      op_j    = 5'b00100,
      op_jr   = 5'b00101, // rs plus imm8
      op_jal  = 5'b00110,
      op_addi = 5'b01000, // rt = rs + imm5
      op_beqz = 5'b01100, // branch offsets relative to PC plus 2
      op_bnez = 5'b01101,
      op_st   = 5'b10000, // mem[rs + imm5] = rt
      op_ld   = 5'b10001, // rt = mem[rs + imm5]
      op_add  = 5'b11000, // rd = rs op rt
      op_sub  = 5'b11001,
      op_and  = 5'b11010,
      op_xor  = 5'b11011
   } opcode_t;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_xor,
      alu_pass_b
   } alu_op_t;

endpackage

// ==== source/pipe_pkg.sv ====
package pipe_pkg;

   // Decoded control bits, carried down the pipe
   typedef struct packed {
      logic               reg_write;
      logic               mem_read;
      logic               mem_write;
      logic               mem_to_reg;
      logic               link;
      logic               branch_zero;
      logic               branch_nonzero;
      logic               jump;
      logic               jump_reg;
      logic               halt;
      logic               alu_src_imm;
      isa_pkg::alu_op_t   alu_op;
      isa_pkg::reg_sel_t  dest;
   } ctrl_t;

   typedef struct packed {
      isa_pkg::word_t instr;
      isa_pkg::word_t pc_plus2;
   } fd_t;

   typedef struct packed {
      ctrl_t          ctrl;
      isa_pkg::word_t rs_val;
      isa_pkg::word_t rt_val;
      isa_pkg::word_t imm;   // Already sign extended
      isa_pkg::word_t pc_plus2;
   } de_t;

   typedef struct packed {
      ctrl_t          ctrl;
      isa_pkg::word_t alu_result;
      isa_pkg::word_t store_data;
      isa_pkg::word_t pc_plus2;
   } em_t;

   typedef struct packed {
      logic              reg_write;
      isa_pkg::reg_sel_t dest;
      logic              halt;
      isa_pkg::word_t    wb_value;
   } mw_t;

endpackage

// ==== source/proc_top.sv ====
`timescale 1ns/1ps

module proc_top (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              load_en,
   input  logic [isa_pkg::mem_addr_width-1:0] load_addr,
   input  logic [isa_pkg::word_width-1:0]     load_data,
   output logic                              err,
   output logic [isa_pkg::word_width-1:0]     pc,
   output logic [isa_pkg::word_width-1:0]     instruction_d,
   output logic                              halted,
   output logic                              wb_write,
   output logic [isa_pkg::reg_sel_width-1:0]  wb_reg,
   output logic [isa_pkg::word_width-1:0]     wb_data
);

   pipe_pkg::fd_t  fetched, fd_q;
   pipe_pkg::de_t  de_d, de_q;
   pipe_pkg::em_t  em_d, em_q;
   pipe_pkg::mw_t  mw_d, mw_q;
   isa_pkg::word_t target;
   logic uses_rt, taken;
   logic stall_front, flush_fd, flush_de;

   regfile_if rf_bus ();

   fetch fetch_i (.clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
                  .load_data(load_data), .stall(stall_front), .redirect(taken),
                  .redirect_target(target), .halt_wb(mw_q.halt),
                  .fetched(fetched), .pc(pc));

   stage_latch #(.payload_t(pipe_pkg::fd_t)) fd_latch (.clk(clk), .reset(reset),
      .stall(stall_front), .flush(flush_fd), .d(fetched), .q(fd_q));

   hazard_unit hazard_i (.src(rf_bus.source), .uses_rt(uses_rt), .de_ctrl(de_q.ctrl),
                         .em_ctrl(em_q.ctrl), .mw_dest(mw_q.dest), .mw_write(mw_q.reg_write),
                         .taken(taken), .stall_front(stall_front), .flush_fd(flush_fd),
                         .flush_de(flush_de));

   decode decode_i (.clk(clk), .reset(reset), .fd(fd_q), .rf(rf_bus.regfile),
                    .de(de_d), .uses_rt(uses_rt), .err(err));

   stage_latch #(.payload_t(pipe_pkg::de_t)) de_latch (.clk(clk), .reset(reset),
      .stall(1'b0), .flush(flush_de), .d(de_d), .q(de_q));

   execute execute_i (.de(de_q), .em(em_d), .taken(taken), .target(target));

   stage_latch #(.payload_t(pipe_pkg::em_t)) em_latch (.clk(clk), .reset(reset),
      .stall(1'b0), .flush(1'b0), .d(em_d), .q(em_q));

   data_memory data_memory_i (.clk(clk), .reset(reset), .em(em_q), .mw(mw_d));

   // HALT parks in write-back until reset
   stage_latch #(.payload_t(pipe_pkg::mw_t)) mw_latch (.clk(clk), .reset(reset),
      .stall(mw_q.halt), .flush(1'b0), .d(mw_d), .q(mw_q));

   // Write-back port into decode's register file
   assign rf_bus.write      = mw_q.reg_write;
   assign rf_bus.write_sel  = mw_q.dest;
   assign rf_bus.write_data = mw_q.wb_value;

   assign instruction_d = fd_q.instr;
   assign halted        = mw_q.halt;
   assign wb_write      = mw_q.reg_write;
   assign wb_reg        = mw_q.dest;
   assign wb_data       = mw_q.wb_value;

endmodule

// ==== source/regfile_if.sv ====
`timescale 1ns/1ps

interface regfile_if;

   isa_pkg::reg_sel_t read1_sel;
   isa_pkg::reg_sel_t read2_sel;
   isa_pkg::word_t    read1_data;
   isa_pkg::word_t    read2_data;
   logic              write;
   isa_pkg::reg_sel_t write_sel;
   isa_pkg::word_t    write_data;

   // Decode owns the array and also picks the read registers
   modport regfile (output read1_sel, read2_sel, read1_data, read2_data,
                    input  write, write_sel, write_data);
   modport writer  (output write, write_sel, write_data);
   modport source  (input  read1_sel, read2_sel);

endinterface

// ==== source/stage_latch.sv ====
`timescale 1ns/1ps

module stage_latch #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     stall,
   input  logic     flush,
   input  payload_t d,
   output payload_t q
);

   // All-zero payload is a bubble, flush beats stall
   always_ff @(posedge clk) begin
      if (reset || flush) begin
         q <= '0;
      end else if (!stall) begin
         q <= d;
      end
   end

endmodule

// ==== tests/proc_properties.sv ====
`timescale 1ns/1ps

module proc_properties (
   input logic          clk,
   input logic          reset,
   input logic          stall_front,
   input logic          flush_fd,
   input logic          flush_de,
   input logic          halted,
   input pipe_pkg::fd_t fd_q,
   input pipe_pkg::de_t de_q
);

   // A flushed de latch carries a bubble into execute
   flush_gives_bubble: assert property (@(posedge clk) disable iff (reset)
      flush_de |=> de_q == '0)
      else $error("de latch did not hold a bubble after a flush");

   hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
      stall_front && !flush_fd |=> $stable(fd_q))
      else $error("fd payload changed during a stall");

   // Only reset clears halted
   halt_is_sticky: assert property (@(posedge clk) disable iff (reset)
      halted |=> halted)
      else $error("halted fell without a reset");

endmodule

bind proc_top proc_properties props_i (.clk(clk), .reset(reset), .stall_front(stall_front),
   .flush_fd(flush_fd), .flush_de(flush_de), .halted(halted), .fd_q(fd_q), .de_q(de_q));

// ==== tests/proc_tb.sv ====
`timescale 1ns/1ps

module proc_tb;

   typedef struct {
      int             dest;  // reg_count marks the end of a program
      isa_pkg::word_t value;
   } wb_row_t;

   logic                       clk;
   logic                       reset;
   logic                       load_en;
   isa_pkg::mem_addr_t         load_addr;
   isa_pkg::word_t             load_data;
   logic                       err;
   isa_pkg::word_t             pc;
   isa_pkg::word_t             instruction_d;
   logic                       halted;
   logic                       wb_write;
   logic [isa_pkg::reg_sel_width-1:0] wb_reg;
   isa_pkg::word_t             wb_data;

   isa_pkg::word_t imem_table [$]; // All programs back to back
   wb_row_t        wb_table [$];
   int             prog_start [$];
   int             prog_len [$];
   int             prog_err [$];
   string          prog_name [$];
   int             seed = 32'ha1fa;
   int             limit_cycles = 0;

   proc_top dut_i (.clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
                   .load_data(load_data), .err(err), .pc(pc), .instruction_d(instruction_d),
                   .halted(halted), .wb_write(wb_write), .wb_reg(wb_reg), .wb_data(wb_data));

   initial clk = 1'b0;
   always #50 clk = ~clk;

   function automatic isa_pkg::word_t encode_alu(isa_pkg::opcode_t op, int rd, int rs, int rt);
      return {op, 3'(rs), 3'(rt), 3'(rd), 2'b00};
   endfunction

   function automatic isa_pkg::word_t encode_imm(isa_pkg::opcode_t op, int rt, int rs, int imm);
      return {op, 3'(rs), 3'(rt), 5'(imm)};
   endfunction

   function automatic isa_pkg::word_t encode_branch(isa_pkg::opcode_t op, int rs, int offset);
      return {op, 3'(rs), 8'(offset)};
   endfunction

   function automatic isa_pkg::word_t encode_jump(isa_pkg::opcode_t op, int offset);
      return {op, 11'(offset)};
   endfunction

   // Word that program p puts at an imem address
   function automatic isa_pkg::word_t loaded_word(input int p, input int addr);
      if (addr < prog_len[p]) begin
         return imem_table[prog_start[p] + addr];
      end
      return {isa_pkg::op_halt, 11'(addr)}; // Spare words hold HALT tagged with their address
   endfunction

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         stop_with_error($sformatf("Fail %s: expected %0h, actual %0h", name, expected, actual));
      end
   endtask

   task automatic add_instr(input isa_pkg::word_t w, input int dest = -1,
                            input isa_pkg::word_t value = '0);
      imem_table.push_back(w);
      if (dest >= 0) begin
         wb_table.push_back('{dest, value}); // This instruction must retire
      end
   endtask

   task automatic end_program(input string name, input int err_expected);
      wb_table.push_back('{isa_pkg::reg_count, '0});
      prog_name.push_back(name);
      prog_err.push_back(err_expected);
      prog_len.push_back(imem_table.size() - prog_start[$]);
   endtask

   task automatic build_tables();
      int a;
      int b;
      int c;
      isa_pkg::word_t r1;
      isa_pkg::word_t r2;
      isa_pkg::word_t r3;
      isa_pkg::word_t r4;
      isa_pkg::word_t r5;
      a  = $random(seed) % 16; // Fits a signed imm5
      b  = $random(seed) % 16;
      c  = $random(seed) % 16;
      r1 = isa_pkg::word_t'(a);
      r2 = r1 + isa_pkg::word_t'(b);
      r3 = r1 + r2;
      r4 = r3 - r1;
      r5 = r4 & r3;

      // Back-to-back dependences all the way down
      prog_start.push_back(imem_table.size());
      add_instr(encode_imm(isa_pkg::op_addi, 1, 0, a), 1, r1);
      add_instr(encode_imm(isa_pkg::op_addi, 2, 1, b), 2, r2);
      add_instr(encode_alu(isa_pkg::op_add, 3, 1, 2), 3, r3);
      add_instr(encode_alu(isa_pkg::op_sub, 4, 3, 1), 4, r4);
      add_instr(encode_alu(isa_pkg::op_and, 5, 4, 3), 5, r5);
      add_instr(encode_alu(isa_pkg::op_xor, 6, 5, 2), 6, r5 ^ r2);
      add_instr(encode_jump(isa_pkg::op_halt, 0));
      end_program("arith_chain", 0);

      // mem[5 + 3] = r1, then read back and used at once
      prog_start.push_back(imem_table.size());
      add_instr(encode_imm(isa_pkg::op_addi, 1, 0, c), 1, isa_pkg::word_t'(c));
      add_instr(encode_imm(isa_pkg::op_addi, 2, 0, 5), 2, 16'd5);
      add_instr(encode_imm(isa_pkg::op_st, 1, 2, 3));
      add_instr(encode_imm(isa_pkg::op_ld, 3, 2, 3), 3, isa_pkg::word_t'(c));
      add_instr(encode_alu(isa_pkg::op_add, 4, 3, 1), 4, isa_pkg::word_t'(2 * c));
      add_instr(encode_jump(isa_pkg::op_halt, 0));
      end_program("store_load", 0);

      // Offset 2 skips exactly one instruction
      prog_start.push_back(imem_table.size());
      add_instr(encode_imm(isa_pkg::op_addi, 1, 0, 0), 1, 16'd0);
      add_instr(encode_imm(isa_pkg::op_addi, 2, 0, 3), 2, 16'd3);
      add_instr(encode_branch(isa_pkg::op_beqz, 1, 2));       // Taken
      add_instr(encode_imm(isa_pkg::op_addi, 3, 0, 9));
      add_instr(encode_branch(isa_pkg::op_bnez, 1, 2));       // Not taken
      add_instr(encode_imm(isa_pkg::op_addi, 4, 0, 4), 4, 16'd4);
      add_instr(encode_branch(isa_pkg::op_bnez, 2, 2));       // Taken
      add_instr(encode_imm(isa_pkg::op_addi, 5, 0, 7));
      add_instr(encode_branch(isa_pkg::op_beqz, 2, 2));       // Not taken
      add_instr(encode_imm(isa_pkg::op_addi, 6, 0, 6), 6, 16'd6);
      add_instr(encode_jump(isa_pkg::op_halt, 0));
      end_program("branches", 0);

      // JAL at byte 2 links 4 and lands on byte 8, J at byte 10 lands on 14
      prog_start.push_back(imem_table.size());
      add_instr(encode_imm(isa_pkg::op_addi, 1, 0, 1), 1, 16'd1);
      add_instr(encode_jump(isa_pkg::op_jal, 4), isa_pkg::reg_link, 16'd4);
      add_instr(encode_imm(isa_pkg::op_addi, 2, 0, 2));
      add_instr(encode_imm(isa_pkg::op_addi, 3, 0, 3));
      add_instr(encode_imm(isa_pkg::op_addi, 4, 0, 4), 4, 16'd4);
      add_instr(encode_jump(isa_pkg::op_j, 2));
      add_instr(encode_imm(isa_pkg::op_addi, 5, 0, 5));
      add_instr(encode_imm(isa_pkg::op_addi, 6, 0, 6), 6, 16'd6);
      add_instr(encode_jump(isa_pkg::op_halt, 0));
      end_program("jumps", 0);

      prog_start.push_back(imem_table.size());
      add_instr(encode_imm(isa_pkg::op_addi, 1, 0, 1), 1, 16'd1);
      add_instr(encode_jump(isa_pkg::op_halt, 0));
      add_instr(encode_imm(isa_pkg::op_addi, 2, 0, 2));   // Never retires
      add_instr(encode_imm(isa_pkg::op_addi, 3, 0, 3));
      end_program("halt", 0);

      prog_start.push_back(imem_table.size());
      add_instr(encode_imm(isa_pkg::op_addi, 1, 0, 1), 1, 16'd1);
      add_instr(16'hf800);                                 // Opcode 11111
      add_instr(encode_imm(isa_pkg::op_addi, 2, 0, 2), 2, 16'd2);
      add_instr(encode_jump(isa_pkg::op_halt, 0));
      end_program("illegal_opcode", 1);
   endtask

   task automatic run_program(input int p, inout int row);
      int             err_seen;
      isa_pkg::word_t halt_pc;
      err_seen = 0;
      @(posedge clk);
      reset <= 1'b1;
      // Whole imem gets loaded so nothing stale survives from the last program
      for (int a = 0; a < isa_pkg::imem_depth; a++) begin
         load_en   <= 1'b1;
         load_addr <= isa_pkg::mem_addr_t'(a);
         load_data <= loaded_word(p, a);
         @(posedge clk);
      end
      load_en <= 1'b0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      do begin
         @(negedge clk);
         if (err) err_seen = 1;
         if (wb_write) begin
            if (wb_table[row].dest == isa_pkg::reg_count) begin
               stop_with_error($sformatf("%s: unexpected write-back to r%0d",
                                         prog_name[p], wb_reg));
            end
            check_value({prog_name[p], " wb_reg"}, wb_table[row].dest, wb_reg);
            check_value({prog_name[p], " wb_data"}, wb_table[row].value, wb_data);
            row++;
         end
      end while (!halted);
      check_value({prog_name[p], " missing write-back"}, isa_pkg::reg_count,
                  wb_table[row].dest);
      row++;

      // Frozen after HALT
      halt_pc = pc;
      repeat (8) begin
         @(negedge clk);
         if (err) err_seen = 1;
         check_value({prog_name[p], " halted"}, 1, halted);
         check_value({prog_name[p], " pc frozen"}, halt_pc, pc);
         check_value({prog_name[p], " write-back after halt"}, 0, wb_write);
      end
      // Decode keeps showing the word at the frozen pc
      check_value({prog_name[p], " instruction_d"},
                  loaded_word(p, int'(pc[isa_pkg::mem_addr_width:1])), instruction_d);
      check_value({prog_name[p], " err"}, prog_err[p], err_seen);
   endtask

   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      stop_with_error($sformatf("Timeout: programs did not finish in %0d cycles",
                                limit_cycles));
   end

   initial begin
      int row;
      reset     = 1'b1;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      row       = 0;
      build_tables();
      limit_cycles = imem_table.size() * 8 +
                     prog_name.size() * (isa_pkg::imem_depth + 10 + 8 + 4);
      for (int p = 0; p < prog_name.size(); p++) begin
         run_program(p, row);
      end
      $display("Everything OK");
      $finish;
   end

endmodule
